//--- tb/rs_input.dat
# en sq stall dv | slot0: fu dest t1 r1 t2 r2 | slot1: same | cdb: v0 tag0 v1 tag1
# expected: busy_mask dest_u0..dest_u4 free_rows_next rs_full (all hex)
# Reset state, two dispatches waiting on tags 10 and 11
1 0 00 0  0 00 00 0 00 0  0 00 00 0 00 0  0 00 0 00  00 00 00 00 00 00 8 0
1 0 00 3  0 01 10 0 00 1  1 02 00 1 11 0  0 00 0 00  00 00 00 00 00 00 6 0
1 0 00 0  0 00 00 0 00 0  0 00 00 0 00 0  0 00 0 00  00 00 00 00 00 00 6 0
# Wakeup issues in the broadcast cycle, same slot match at dispatch
1 0 00 0  0 00 00 0 00 0  0 00 00 0 00 0  1 10 0 00  01 01 00 00 00 00 7 0
1 0 00 1  2 03 11 0 00 1  0 00 00 0 00 0  1 11 0 00  04 00 00 02 00 00 7 0
1 0 00 0  0 00 00 0 00 0  0 00 00 0 00 0  0 00 0 00  08 00 00 00 03 00 8 0
# Six rows wait on tag 14, then all wake together
1 0 00 3  0 04 14 0 00 1  0 05 14 0 00 1  0 00 0 00  00 00 00 00 00 00 6 0
1 0 00 3  0 06 14 0 00 1  1 07 14 0 00 1  0 00 0 00  00 00 00 00 00 00 4 0
1 0 00 3  2 08 14 0 00 1  3 09 14 0 00 1  0 00 0 00  00 00 00 00 00 00 2 0
1 0 00 0  0 00 00 0 00 0  0 00 00 0 00 0  1 14 0 00  1f 04 05 07 08 09 7 0
1 0 00 0  0 00 00 0 00 0  0 00 00 0 00 0  0 00 0 00  01 06 00 00 00 00 8 0
# ALU unit 0 stalled, unit 1 takes the lowest row
1 0 00 3  0 0a 00 1 00 1  0 0b 00 1 00 1  0 00 0 00  00 00 00 00 00 00 6 0
1 0 01 0  0 00 00 0 00 0  0 00 00 0 00 0  0 00 0 00  02 00 0a 00 00 00 7 0
1 0 00 0  0 00 00 0 00 0  0 00 00 0 00 0  0 00 0 00  01 0b 00 00 00 00 8 0
# Fill all eight rows, extra dispatches dropped
1 0 00 3  0 10 1a 0 00 1  0 11 1a 0 00 1  0 00 0 00  00 00 00 00 00 00 6 0
1 0 00 3  0 12 1a 0 00 1  0 13 1a 0 00 1  0 00 0 00  00 00 00 00 00 00 4 0
1 0 00 3  0 14 1a 0 00 1  0 15 1a 0 00 1  0 00 0 00  00 00 00 00 00 00 2 0
1 0 00 3  0 16 1a 0 00 1  0 17 1a 0 00 1  0 00 0 00  00 00 00 00 00 00 0 0
1 0 00 3  0 18 00 1 00 1  0 19 00 1 00 1  0 00 0 00  00 00 00 00 00 00 0 1
1 0 00 0  0 00 00 0 00 0  0 00 00 0 00 0  0 00 0 00  00 00 00 00 00 00 0 1
1 0 00 3  0 18 00 1 00 1  0 19 00 1 00 1  0 00 1 1a  03 10 11 00 00 00 2 1
# Squash empties the table
0 1 00 0  0 00 00 0 00 0  0 00 00 0 00 0  0 00 0 00  00 00 00 00 00 00 8 0
1 0 00 0  0 00 00 0 00 0  0 00 00 0 00 0  0 00 0 00  00 00 00 00 00 00 8 0
# Enable low blocks dispatch and issue, wakeup is kept
1 0 00 3  0 1c 1b 0 00 1  2 1d 00 1 1b 0  0 00 0 00  00 00 00 00 00 00 6 0
0 0 00 3  1 1e 00 1 00 1  3 1f 00 1 00 1  1 1b 0 00  00 00 00 00 00 00 6 0
0 0 00 0  0 00 00 0 00 0  0 00 00 0 00 0  0 00 0 00  00 00 00 00 00 00 6 0
1 0 00 0  0 00 00 0 00 0  0 00 00 0 00 0  0 00 0 00  09 1c 00 00 1d 00 8 0
1 0 00 0  0 00 00 0 00 0  0 00 00 0 00 0  0 00 0 00  00 00 00 00 00 00 8 0
# Slot 1 same slot match, stalls on both ALUs and the load unit
1 0 00 3  1 08 00 1 00 1  0 09 1c 0 00 1  0 00 1 1c  00 00 00 00 00 00 6 0
1 0 07 0  0 00 00 0 00 0  0 00 00 0 00 0  0 00 0 00  00 00 00 00 00 00 6 0
1 0 02 0  0 00 00 0 00 0  0 00 00 0 00 0  0 00 0 00  05 09 00 08 00 00 8 0
1 0 00 0  0 00 00 0 00 0  0 00 00 0 00 0  0 00 0 00  00 00 00 00 00 00 8 0
# Two broadcast slots wake both branch sources at once
1 0 00 3  3 11 05 0 06 0  0 12 00 1 00 1  0 00 0 00  00 00 00 00 00 00 6 0
1 0 00 0  0 00 00 0 00 0  0 00 00 0 00 0  1 05 1 06  11 12 00 00 00 11 8 0
1 0 00 0  0 00 00 0 00 0  0 00 00 0 00 0  0 00 0 00  00 00 00 00 00 00 8 0

//--- compile.f
source/rs_pkg.sv
source/prio_select.sv
source/tag_cam.sv
source/reservation_station.sv
source/issue_window.sv
tb/issue_window_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the instruction window testbench with Verilator
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module issue_window_tb -f compile.f -Mdir obj_dir \
	&& ./obj_dir/Vissue_window_tb > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
if grep -q "Verification failed" sim.log; then
	exit 1
fi
exit 0

//--- tb/issue_window_tb.sv
// Instruction window testbench
`default_nettype none

module issue_window_tb
	import rs_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int    CLK_PERIOD      = 100;
	localparam int    RESET_CYCLES    = 8;
	// Spare cycles past the vector count
	localparam int    WATCHDOG_MARGIN = 20;
	localparam int    FIELDS          = 28;
	localparam string DATA_FILE       = "tb/rs_input.dat";

	// One data file line, stimulus then expected outputs
	typedef struct packed {
		logic                    en;
		logic                    squash;
		logic      [NUM_FU-1:0]  stall;
		logic      [SS_SIZE-1:0] dv;
		rs_row_t   [SS_SIZE-1:0] inst;
		cdb_t      [SS_SIZE-1:0] cdb;
		logic      [NUM_FU-1:0]  exp_busy;
		phys_tag_t [NUM_FU-1:0]  exp_dest;
		row_count_t              exp_free;
		logic                    exp_full;
	} vector_t;

	// DUT ports
	logic                  clock;
	logic                  rst_n;
	logic                  enable;
	logic                  squash;
	logic    [SS_SIZE-1:0] dispatch_valid;
	rs_row_t [SS_SIZE-1:0] inst_in;
	cdb_t    [SS_SIZE-1:0] cdb_in;
	logic    [NUM_FU-1:0]  issue_stall;
	rs_row_t [NUM_FU-1:0]  issue_out;
	row_count_t            free_rows_next;
	logic                  rs_full;

	// Vector storage and bookkeeping
	vector_t vectors[$];
	int      vector_lines[$];
	int      fields[FIELDS];
	int      error_count;
	int      check_count;
	int      watchdog_ns = 0;

	issue_window dut0 (
		.clock          (clock),
		.rst_n          (rst_n),
		.enable         (enable),
		.dispatch_valid (dispatch_valid),
		.inst_in        (inst_in),
		.cdb_in         (cdb_in),
		.issue_stall    (issue_stall),
		.squash         (squash),
		.issue_out      (issue_out),
		.free_rows_next (free_rows_next),
		.rs_full        (rs_full)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	//////////////////////////////////////////////////////////////////////
	// Data file parsing
	//////////////////////////////////////////////////////////////////////

	// Whitespace separated hex columns into fields
	task automatic split_fields(input string text, output int count);
		int         start;
		logic [7:0] c;
		string      token;
		start = -1;
		count = 0;
		// End of text acts as a last separator
		for (int i = 0; i <= text.len(); i++) begin
			c = (i < text.len()) ? text.getc(i) : 8'h20;
			if (c == 8'h20 || c == 8'h09 || c == 8'h0a || c == 8'h0d) begin
				if (start >= 0) begin
					token = text.substr(start, i - 1);
					if (count < FIELDS) begin
						fields[count] = token.atohex();
					end
					count++;
					start = -1;
				end
			end else if (start < 0) begin
				start = i;
			end
		end
	endtask

	function automatic vector_t make_vector();
		vector_t v;
		int      b;
		v        = '0;
		v.en     = fields[0][0];
		v.squash = fields[1][0];
		v.stall  = NUM_FU'(fields[2]);
		v.dv     = SS_SIZE'(fields[3]);
		// Six columns per dispatch slot
		for (int i = 0; i < SS_SIZE; i++) begin
			b = 4 + 6 * i;
			v.inst[i].valid_inst = v.dv[i];
			v.inst[i].fu_type    = fu_type_e'(fields[b][1:0]);
			// Opcode only marks the row, tied to its destination
			v.inst[i].opcode     = opcode_t'(fields[b + 1]);
			v.inst[i].dest_tag   = phys_tag_t'(fields[b + 1]);
			v.inst[i].t1.tag     = phys_tag_t'(fields[b + 2]);
			v.inst[i].t1.ready   = fields[b + 3][0];
			v.inst[i].t2.tag     = phys_tag_t'(fields[b + 4]);
			v.inst[i].t2.ready   = fields[b + 5][0];
		end
		for (int i = 0; i < SS_SIZE; i++) begin
			v.cdb[i].valid = fields[16 + 2 * i][0];
			v.cdb[i].tag   = phys_tag_t'(fields[17 + 2 * i]);
		end
		v.exp_busy = NUM_FU'(fields[20]);
		for (int u = 0; u < NUM_FU; u++) begin
			v.exp_dest[u] = phys_tag_t'(fields[21 + u]);
		end
		v.exp_free = row_count_t'(fields[26]);
		v.exp_full = fields[27][0];
		return v;
	endfunction

	task automatic load_vectors(output bit ok);
		int    fd;
		int    line_no;
		int    count;
		string text;
		ok      = 1'b1;
		line_no = 0;
		fd      = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open %s, there is no stimulus to run", DATA_FILE);
			ok = 1'b0;
			return;
		end
		while ($fgets(text, fd) != 0) begin
			line_no++;
			split_fields(text, count);
			// Hash starts a comment line
			if (count == 0 || text.getc(0) == 8'h23) begin
				continue;
			end
			if (count != FIELDS) begin
				$display("Line %0d of %s holds %0d fields but %0d are needed",
					line_no, DATA_FILE, count, FIELDS);
				ok = 1'b0;
			end else begin
				vectors.push_back(make_vector());
				vector_lines.push_back(line_no);
			end
		end
		$fclose(fd);
		if (vectors.size() == 0) begin
			$display("%s holds no test vectors", DATA_FILE);
			ok = 1'b0;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Drive and check
	//////////////////////////////////////////////////////////////////////

	task automatic apply_vector(input vector_t v);
		enable         <= v.en;
		squash         <= v.squash;
		issue_stall    <= v.stall;
		dispatch_valid <= v.dv;
		inst_in        <= v.inst;
		cdb_in         <= v.cdb;
	endtask

	task automatic check_value(input string name, input int line_no,
		input logic [31:0] actual, input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] line %0d %s: got 0x%h, expected 0x%h",
				line_no, name, actual, expected);
		end
	endtask

	task automatic check_outputs(input vector_t v, input int line_no);
		for (int u = 0; u < NUM_FU; u++) begin
			check_value($sformatf("issue_out[%0d].busy", u), line_no,
				32'(issue_out[u].busy), 32'(v.exp_busy[u]));
			// Payload only matters on a handoff
			if (v.exp_busy[u]) begin
				check_value($sformatf("issue_out[%0d].dest_tag", u), line_no,
					32'(issue_out[u].dest_tag), 32'(v.exp_dest[u]));
			end
		end
		check_value("free_rows_next", line_no, 32'(free_rows_next), 32'(v.exp_free));
		check_value("rs_full", line_no, 32'(rs_full), 32'(v.exp_full));
	endtask

	initial begin
		bit loaded;
		rst_n          = 1'b0;
		enable         = 1'b0;
		squash         = 1'b0;
		issue_stall    = '0;
		dispatch_valid = '0;
		inst_in        = '0;
		cdb_in         = '0;
		error_count    = 0;
		check_count    = 0;
		load_vectors(loaded);
		if (!loaded) begin
			error_count++;
		end else begin
			watchdog_ns = (vectors.size() + RESET_CYCLES + WATCHDOG_MARGIN) * CLK_PERIOD;
			repeat (RESET_CYCLES) @(posedge clock);
			rst_n <= 1'b1;
			// Drive on the rising edge, sample mid cycle
			foreach (vectors[i]) begin
				@(posedge clock);
				apply_vector(vectors[i]);
				@(negedge clock);
				check_outputs(vectors[i], vector_lines[i]);
			end
			@(posedge clock);
		end
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// Watchdog, armed once the vector count is known
	initial begin
		wait (watchdog_ns > 0);
		#(watchdog_ns);
		$display("Watchdog expired after %0d ns, the run did not finish", watchdog_ns);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/issue_window.sv
// Instruction window top
`default_nettype none

module issue_window
	import rs_pkg::*;
(
	input  wire logic                  clock,
	input  wire logic                  rst_n,
	// Dispatch is gated by this as well as issue
	input  wire logic                  enable,
	input  wire logic    [SS_SIZE-1:0] dispatch_valid,
	input  wire rs_row_t [SS_SIZE-1:0] inst_in,
	// Two slot result broadcast
	input  wire cdb_t    [SS_SIZE-1:0] cdb_in,
	input  wire logic    [NUM_FU-1:0]  issue_stall,
	// Branch recovery flush
	input  wire logic                  squash,
	// One row per unit, busy marks a handoff
	output rs_row_t      [NUM_FU-1:0]  issue_out,
	output row_count_t                 free_rows_next,
	output logic                       rs_full
);

	//////////////////////////////////////////////////////////////////////
	// Station
	//////////////////////////////////////////////////////////////////////

	reservation_station rs0 (
		.clock          (clock),
		.rst_n          (rst_n),
		.enable         (enable),
		.dispatch_valid (dispatch_valid),
		.inst_in        (inst_in),
		.cdb_in         (cdb_in),
		.issue_stall    (issue_stall),
		.squash         (squash),
		.issue_out      (issue_out),
		.free_rows_next (free_rows_next),
		.rs_full        (rs_full)
	);

endmodule

`default_nettype wire

//--- source/reservation_station.sv
// Eight row reservation station
`default_nettype none

module reservation_station
	import rs_pkg::*;
(
	input  wire logic                  clock,
	input  wire logic                  rst_n,
	input  wire logic                  enable,
	input  wire logic    [SS_SIZE-1:0] dispatch_valid,
	input  wire rs_row_t [SS_SIZE-1:0] inst_in,
	input  wire cdb_t    [SS_SIZE-1:0] cdb_in,
	input  wire logic    [NUM_FU-1:0]  issue_stall,
	input  wire logic                  squash,
	output rs_row_t      [NUM_FU-1:0]  issue_out,
	output row_count_t                 free_rows_next,
	output logic                       rs_full
);

	// Registered row table and its next state
	rs_row_t [RS_SIZE-1:0]        rs_table;
	rs_row_t [RS_SIZE-1:0]        rs_table_next;

	// Wakeup match
	phys_tag_t [RS_SIZE-1:0][1:0] cam_tags;
	logic      [RS_SIZE-1:0][1:0] cam_ready;
	logic      [RS_SIZE-1:0][1:0] cam_hits;

	// Dispatch slot placement
	logic      [RS_SIZE-1:0]      free_req;
	row_idx_t  [SS_SIZE-1:0]      disp_idx;
	logic      [SS_SIZE-1:0]      disp_ok;

	// Issue requests per unit type
	logic      [RS_SIZE-1:0]      row_ready;
	logic      [RS_SIZE-1:0]      alu_req;
	logic      [RS_SIZE-1:0]      ld_req;
	logic      [RS_SIZE-1:0]      mult_req;
	logic      [RS_SIZE-1:0]      br_req;

	// Grants before and after stall shifting
	row_idx_t  [NUM_FU-1:0]       raw_idx;
	logic      [NUM_FU-1:0]       raw_valid;
	row_idx_t  [NUM_FU-1:0]       fu_idx;
	logic      [NUM_FU-1:0]       fu_valid;

	//////////////////////////////////////////////////////////////////////
	// Wakeup
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int r = 0; r < RS_SIZE; r++) begin
			cam_tags[r][0]  = rs_table[r].t1.tag;
			cam_tags[r][1]  = rs_table[r].t2.tag;
			cam_ready[r][0] = rs_table[r].t1.ready;
			cam_ready[r][1] = rs_table[r].t2.ready;
		end
	end

	tag_cam cam0 (
		.src_tags  (cam_tags),
		.src_ready (cam_ready),
		.cdb_in    (cdb_in),
		.hits      (cam_hits)
	);

	//////////////////////////////////////////////////////////////////////
	// Dispatch into free rows
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int r = 0; r < RS_SIZE; r++) begin
			free_req[r] = !rs_table[r].busy;
		end
	end

	// Slot 0 takes the lowest free row and slot 1 the next
	prio_select #(.NUM_GNTS(SS_SIZE)) sel_disp (
		.req       (free_req),
		.en        (enable),
		.gnt_idx   (disp_idx),
		.gnt_valid (disp_ok)
	);

	//////////////////////////////////////////////////////////////////////
	// Issue select
	//////////////////////////////////////////////////////////////////////

	// A broadcast this cycle already counts as ready
	always_comb begin
		for (int r = 0; r < RS_SIZE; r++) begin
			row_ready[r] = rs_table[r].busy &&
				(rs_table[r].t1.ready || cam_hits[r][0]) &&
				(rs_table[r].t2.ready || cam_hits[r][1]);
			alu_req[r]  = row_ready[r] && rs_table[r].fu_type == FU_ALU;
			ld_req[r]   = row_ready[r] && rs_table[r].fu_type == FU_LD;
			mult_req[r] = row_ready[r] && rs_table[r].fu_type == FU_MULT;
			br_req[r]   = row_ready[r] && rs_table[r].fu_type == FU_BR;
		end
	end

	prio_select #(.NUM_GNTS(ALU_COUNT)) sel_alu (
		.req       (alu_req),
		.en        (enable),
		.gnt_idx   (raw_idx[ALU_BASE +: ALU_COUNT]),
		.gnt_valid (raw_valid[ALU_BASE +: ALU_COUNT])
	);

	prio_select #(.NUM_GNTS(1)) sel_ld (
		.req       (ld_req),
		.en        (enable),
		.gnt_idx   (raw_idx[LD_BASE +: 1]),
		.gnt_valid (raw_valid[LD_BASE +: 1])
	);

	prio_select #(.NUM_GNTS(1)) sel_mult (
		.req       (mult_req),
		.en        (enable),
		.gnt_idx   (raw_idx[MULT_BASE +: 1]),
		.gnt_valid (raw_valid[MULT_BASE +: 1])
	);

	prio_select #(.NUM_GNTS(1)) sel_br (
		.req       (br_req),
		.en        (enable),
		.gnt_idx   (raw_idx[BR_BASE +: 1]),
		.gnt_valid (raw_valid[BR_BASE +: 1])
	);

	// Stall shifting
	always_comb begin
		int slot;
		fu_idx   = '0;
		fu_valid = '0;
		slot     = 0;
		// ALU grants slide onto the unstalled units in unit order
		for (int u = 0; u < ALU_COUNT; u++) begin
			if (!issue_stall[ALU_BASE + u]) begin
				for (int k = 0; k < ALU_COUNT; k++) begin
					if (k == slot) begin
						fu_idx[ALU_BASE + u]   = raw_idx[ALU_BASE + k];
						fu_valid[ALU_BASE + u] = raw_valid[ALU_BASE + k];
					end
				end
				slot = slot + 1;
			end
		end
		// Single unit types just lose the grant
		for (int u = LD_BASE; u < NUM_FU; u++) begin
			fu_idx[u]   = raw_idx[u];
			fu_valid[u] = raw_valid[u] && !issue_stall[u];
		end
	end

	// Issued rows leave with both sources marked ready
	always_comb begin
		for (int u = 0; u < NUM_FU; u++) begin
			issue_out[u] = '0;
			if (fu_valid[u]) begin
				issue_out[u]          = rs_table[fu_idx[u]];
				issue_out[u].t1.ready = 1'b1;
				issue_out[u].t2.ready = 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Next table state
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		rs_table_next = rs_table;
		// Latch wakeups first
		for (int r = 0; r < RS_SIZE; r++) begin
			rs_table_next[r].t1.ready = rs_table[r].t1.ready || cam_hits[r][0];
			rs_table_next[r].t2.ready = rs_table[r].t2.ready || cam_hits[r][1];
		end
		// Free issued rows
		for (int u = 0; u < NUM_FU; u++) begin
			if (fu_valid[u]) begin
				rs_table_next[fu_idx[u]] = '0;
			end
		end
		// Fill granted free rows
		// A same-slot broadcast counts as ready
		for (int i = 0; i < SS_SIZE; i++) begin
			if (dispatch_valid[i] && inst_in[i].valid_inst && disp_ok[i]) begin
				rs_table_next[disp_idx[i]]          = inst_in[i];
				rs_table_next[disp_idx[i]].busy     = 1'b1;
				rs_table_next[disp_idx[i]].t1.ready = inst_in[i].t1.ready ||
					(cdb_in[i].valid && cdb_in[i].tag == inst_in[i].t1.tag);
				rs_table_next[disp_idx[i]].t2.ready = inst_in[i].t2.ready ||
					(cdb_in[i].valid && cdb_in[i].tag == inst_in[i].t2.tag);
			end
		end
		// Squash overrides everything
		if (squash) begin
			rs_table_next = '0;
		end
	end

	// Advisory count for the sender
	always_comb begin
		free_rows_next = '0;
		for (int r = 0; r < RS_SIZE; r++) begin
			free_rows_next = free_rows_next + row_count_t'(!rs_table_next[r].busy);
		end
	end

	always_comb begin
		rs_full = 1'b1;
		for (int r = 0; r < RS_SIZE; r++) begin
			rs_full = rs_full && rs_table[r].busy;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rs_table <= '0;
		end else begin
			rs_table <= rs_table_next;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Any live broadcast slot carrying this tag
	function automatic logic tag_on_cdb(cdb_t [SS_SIZE-1:0] cdb, phys_tag_t tag);
		logic seen;
		seen = 1'b0;
		for (int c = 0; c < SS_SIZE; c++) begin
			if (cdb[c].valid && cdb[c].tag == tag) begin
				seen = 1'b1;
			end
		end
		return seen;
	endfunction

	for (genvar u = 0; u < NUM_FU; u++) begin : g_chk
		// Selector output only ever names an occupied row
		a_issue_busy: assert property (@(posedge clock) disable iff (!rst_n)
			fu_valid[u] |-> rs_table[fu_idx[u]].busy);
		// Each source held ready or carried on the broadcast itself
		a_issue_ready: assert property (@(posedge clock) disable iff (!rst_n)
			fu_valid[u] |->
				(rs_table[fu_idx[u]].t1.ready ||
					tag_on_cdb(cdb_in, rs_table[fu_idx[u]].t1.tag)) &&
				(rs_table[fu_idx[u]].t2.ready ||
					tag_on_cdb(cdb_in, rs_table[fu_idx[u]].t2.tag)));
	end

endmodule

`default_nettype wire

//--- source/tag_cam.sv
// Source tag match array
`default_nettype none

module tag_cam
	import rs_pkg::*;
(
	// Both sources of every row
	input  wire phys_tag_t [RS_SIZE-1:0][1:0] src_tags,
	input  wire logic      [RS_SIZE-1:0][1:0] src_ready,
	// Result broadcast slots
	input  wire cdb_t      [SS_SIZE-1:0]      cdb_in,
	output logic           [RS_SIZE-1:0][1:0] hits
);

	//////////////////////////////////////////////////////////////////////
	// Compare every waiting source against every live broadcast
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		hits = '0;
		for (int r = 0; r < RS_SIZE; r++) begin
			for (int s = 0; s < 2; s++) begin
				// Already ready sources never report a hit
				if (!src_ready[r][s]) begin
					for (int c = 0; c < SS_SIZE; c++) begin
						if (cdb_in[c].valid && cdb_in[c].tag == src_tags[r][s]) begin
							hits[r][s] = 1'b1;
						end
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- source/prio_select.sv
// Multi-grant priority selector
`default_nettype none

module prio_select
	import rs_pkg::*;
#(
	// Grants handed out per cycle
	parameter int NUM_GNTS = 1
) (
	input  wire logic [RS_SIZE-1:0]   req,
	input  wire logic                 en,
	output row_idx_t [NUM_GNTS-1:0]   gnt_idx,
	output logic     [NUM_GNTS-1:0]   gnt_valid
);

	//////////////////////////////////////////////////////////////////////
	// Lowest index first, encoded straight to row numbers
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		int found;
		gnt_idx   = '0;
		gnt_valid = '0;
		found     = 0;
		// Walk rows upward, k-th set request lands on grant k
		for (int i = 0; i < RS_SIZE; i++) begin
			if (en && req[i]) begin
				for (int k = 0; k < NUM_GNTS; k++) begin
					if (k == found) begin
						gnt_idx[k]   = row_idx_t'(i);
						gnt_valid[k] = 1'b1;
					end
				end
				// Past NUM_GNTS this just stops matching
				found = found + 1;
			end
		end
	end

	// Each pair of live grants must point at distinct rows
	for (genvar a = 0; a < NUM_GNTS; a++) begin : g_uniq_a
		for (genvar b = a + 1; b < NUM_GNTS; b++) begin : g_uniq_b
			always_comb begin
				a_gnt_unique: assert #0 (!(gnt_valid[a] && gnt_valid[b] &&
					gnt_idx[a] == gnt_idx[b]))
				else
					$error("prio_select grants %0d and %0d share row %0h",
						a, b, gnt_idx[a]);
			end
		end
	end

endmodule

`default_nettype wire

//--- source/rs_pkg.sv
// Reservation station shared types
`default_nettype none

package rs_pkg;

	//////////////////////////////////////////////////////////////////////
	// Machine sizes
	//////////////////////////////////////////////////////////////////////

	// Dispatch and broadcast width
	localparam int SS_SIZE      = 2;
	// Rows in the instruction window
	localparam int RS_SIZE      = 8;
	localparam int NUM_PHYS_REG = 32;
	// Physical tag width follows the register file size
	localparam int PREG_W       = $clog2(NUM_PHYS_REG);
	localparam int NUM_FU       = 5;
	localparam int ROW_IDX_W    = $clog2(RS_SIZE);
	// Free count must reach RS_SIZE itself
	localparam int COUNT_W      = $clog2(RS_SIZE + 1);

	//////////////////////////////////////////////////////////////////////
	// Function unit layout on the issue ports
	//////////////////////////////////////////////////////////////////////

	// Two ALUs sit on ports 0 and 1
	localparam int ALU_BASE     = 0;
	localparam int ALU_COUNT    = 2;
	localparam int LD_BASE      = 2;
	localparam int MULT_BASE    = 3;
	localparam int BR_BASE      = 4;

	//////////////////////////////////////////////////////////////////////
	// Scalar types
	//////////////////////////////////////////////////////////////////////

	typedef logic [PREG_W-1:0]    phys_tag_t;
	typedef logic [ROW_IDX_W-1:0] row_idx_t;
	typedef logic [COUNT_W-1:0]   row_count_t;
	// Opaque to the station, carried through to the unit
	typedef logic [7:0]           opcode_t;

	// Which kind of unit a row needs
	typedef enum logic [1:0] {
		FU_ALU  = 2'd0,
		FU_LD   = 2'd1,
		FU_MULT = 2'd2,
		FU_BR   = 2'd3
	} fu_type_e;

	//////////////////////////////////////////////////////////////////////
	// Structured types
	//////////////////////////////////////////////////////////////////////

	// One source operand, tag plus ready flag
	typedef struct packed {
		phys_tag_t tag;
		logic      ready;
	} src_operand_t;

	// Full row of the window, also the issue payload
	typedef struct packed {
		logic         busy;
		logic         valid_inst;
		fu_type_e     fu_type;
		opcode_t      opcode;
		phys_tag_t    dest_tag;
		src_operand_t t1;
		src_operand_t t2;
	} rs_row_t;

	// One result broadcast slot
	typedef struct packed {
		logic      valid;
		phys_tag_t tag;
	} cdb_t;

endpackage

`default_nettype wire
